/* sim.f */
hw/rsDataPkg.sv
hw/rsCtrlPkg.sv
hw/fwdDecode.sv
hw/operandForward.sv
hw/rsForwardTop.sv
dv/rsForward_props.sv
dv/tbRsForward.sv

/* run.sh */
#!/bin/sh
# compile and run the forward path testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tbRsForward \
  -f sim.f

# keep running past assertion errors so the testbench prints its summary
./obj_dir/VtbRsForward +verilator+error+limit+1000 > "$LOG" 2>&1
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"

/* dv/tbRsForward.sv */
// testbench for the reservation station forward path with a reference model and a checker
`timescale 1ns/1ps

module tbRsForward
  import rsDataPkg::*;
  import rsCtrlPkg::*;
();

  localparam int LOW_W     = 16;    // DUT runs with its default parameters
  localparam bit FILL_ONES = 1'b0;
  localparam int LAST_UNIT = 9;

  localparam int STALL_CYCLES = 120;
  localparam int RAND_CYCLES  = 1000;

  // reset, directed tests, stall and random runs need about 1200 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  // test ids ride along with each item so an error names its test
  localparam int T_RESET    = 0;
  localparam int T_FORWARD  = 1;
  localparam int T_PRIORITY = 2;
  localparam int T_SIGN     = 3;
  localparam int T_STALL    = 4;
  localparam int T_RANDOM   = 5;
  localparam int T_DRAIN    = 6;

  logic     clk;
  logic     rst;
  logic     stall;
  fwdPair_t codes;
  opIn_t    opIn;
  logic     sxtEn;
  fuBus_t   fuLive;
  fuBus_t   fuLate;
  opData_t  newData;

  int seed = 32'hfd0f_c4c7;
  int testId;
  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;

  // model copy of the item held in the decode register
  fwdPair_t pendCodes;
  opIn_t    pendOpIn;
  logic     pendSxt;
  int       pendTest;
  opData_t  lastExp;
  int       lastTest;

  opData_t expQ[$];
  int      testQ[$];

  rsForwardTop i_dut (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .codes   (codes),
    .opIn    (opIn),
    .sxtEn   (sxtEn),
    .fuLive  (fuLive),
    .fuLate  (fuLate),
    .newData (newData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic string testLabel(input int id);
    string name;
    case (id)
      T_RESET:    name = "reset";
      T_FORWARD:  name = "forward";
      T_PRIORITY: name = "priority";
      T_SIGN:     name = "sign_fill";
      T_STALL:    name = "stall";
      T_RANDOM:   name = "random";
      default:    name = "drain";
    endcase
    return name;
  endfunction

  function automatic int codeUnit(input fwdCode_t code);
    int unit;
    unit = int'(code);
    if (unit > LAST_UNIT) begin
      unit = LAST_UNIT;  // codes 10 to 14 alias onto the last unit
    end
    return unit;
  endfunction

  // expected operand from one cycle's codes and the buses of the cycle after
  function automatic opData_t refOperand(
    input fwdPair_t pair,
    input opIn_t    opVals,
    input logic     sxt,
    input fuBus_t   liveBus,
    input fuBus_t   lateBus
  );
    opData_t val;
    if (pair.live != FWD_NONE) begin
      val = liveBus.fu[codeUnit(pair.live)];
    end else if (opVals.auxEn) begin
      val = opVals.auxData;
    end else if (pair.late != FWD_NONE) begin
      val = lateBus.fu[codeUnit(pair.late)];
    end else begin
      val = opVals.oldData;
    end
    // the tag bit and the low field pass untouched
    if (sxt) begin
      val[DATA_WIDTH-2:LOW_W] = FILL_ONES ? '1 : '0;
    end
    return val;
  endfunction

  function automatic opData_t randomWord();
    logic [95:0] bits;
    bits = {$random(seed), $random(seed), $random(seed)};
    return bits[DATA_WIDTH-1:0];
  endfunction

  function automatic fuBus_t randomBus();
    fuBus_t bus;
    for (int u = 0; u < NUM_FU; u++) begin
      bus.fu[u] = randomWord();
    end
    return bus;
  endfunction

  function automatic fwdCode_t randomCode();
    logic [31:0] r;
    r = $random(seed);
    return r[3:0];
  endfunction

  // a code that names a unit, never the none value
  function automatic fwdCode_t validCode();
    logic [31:0] r;
    r = $random(seed);
    return 4'(r % 32'd15);
  endfunction

  function automatic logic randomBit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic randomStall();
    logic [31:0] r;
    r = $random(seed);
    return (r % 32'd5) == 32'd0;  // about one cycle in five
  endfunction

  function automatic fwdPair_t makePair(input fwdCode_t liveCode, input fwdCode_t lateCode);
    fwdPair_t p;
    p.live = liveCode;
    p.late = lateCode;
    return p;
  endfunction

  function automatic opIn_t makeOpIn(input logic aux);
    opIn_t o;
    o.oldData = randomWord();
    o.auxData = randomWord();
    o.auxEn   = aux;
    return o;
  endfunction

  task automatic driveCycle(
    input fwdPair_t c,
    input opIn_t    o,
    input logic     sx,
    input logic     st,
    input int       id
  );
    @(posedge clk);
    codes  <= c;
    opIn   <= o;
    sxtEn  <= sx;
    stall  <= st;
    testId <= id;
    fuLive <= randomBus();
    fuLate <= randomBus();
  endtask

  task automatic finishRun(input bit timedOut);
    int propFails;
    propFails = i_dut.propsInst.failCount;
    $display("checks %0d, compare errors %0d, assertion failures %0d",
             checkCount, errorCount, propFails);
    if (timedOut || errorCount != 0 || propFails != 0) begin
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  endtask

  // reference model, sees the values every DUT register sees at this edge
  always @(posedge clk) begin
    if (rst) begin
      pendCodes = makePair(FWD_NONE, FWD_NONE);  // decode resets to the stored value path
      pendOpIn  = '0;
      pendSxt   = 1'b0;
      pendTest  = T_RESET;
      lastExp   = '0;
      lastTest  = T_RESET;
      expQ.push_back(lastExp);
      testQ.push_back(lastTest);
    end else if (stall) begin
      expQ.push_back(lastExp);
      testQ.push_back(lastTest);
    end else begin
      lastExp  = refOperand(pendCodes, pendOpIn, pendSxt, fuLive, fuLate);
      lastTest = pendTest;
      expQ.push_back(lastExp);
      testQ.push_back(lastTest);
      pendCodes = codes;
      pendOpIn  = opIn;
      pendSxt   = sxtEn;
      pendTest  = testId;
    end
  end

  // newData is settled by the falling edge
  always @(negedge clk) begin
    opData_t expVal;
    int      id;
    if (expQ.size() != 0) begin
      expVal = expQ.pop_front();
      id     = testQ.pop_front();
      checkCount++;
      if (newData !== expVal) begin
        errorCount++;
        $display("Error %s: expected %h actual %h", testLabel(id), expVal, newData);
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the stimulus did not finish", cycleCount);
      finishRun(1'b1);
    end
  end

  initial begin
    int i;
    rst    = 1'b1;
    stall  = 1'b0;
    codes  = makePair(FWD_NONE, FWD_NONE);
    opIn   = '0;
    sxtEn  = 1'b0;
    fuLive = '0;
    fuLate = '0;
    testId = T_RESET;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // each live code alone, then each late code alone
    for (i = 0; i < 16; i++) begin
      driveCycle(makePair(fwdCode_t'(i), FWD_NONE), makeOpIn(1'b0), 1'b0, 1'b0, T_FORWARD);
    end
    for (i = 0; i < 16; i++) begin
      driveCycle(makePair(FWD_NONE, fwdCode_t'(i)), makeOpIn(1'b0), 1'b0, 1'b0, T_FORWARD);
    end

    repeat (4) driveCycle(makePair(validCode(), validCode()), makeOpIn(1'b0), 1'b0, 1'b0,
                          T_PRIORITY);
    repeat (2) driveCycle(makePair(validCode(), validCode()), makeOpIn(1'b1), 1'b0, 1'b0,
                          T_PRIORITY);
    repeat (3) driveCycle(makePair(FWD_NONE, validCode()), makeOpIn(1'b1), 1'b0, 1'b0,
                          T_PRIORITY);  // aux beats the late path

    // fill applied to every source kind
    repeat (2) driveCycle(makePair(validCode(), FWD_NONE), makeOpIn(1'b0), 1'b1, 1'b0, T_SIGN);
    repeat (2) driveCycle(makePair(FWD_NONE, validCode()), makeOpIn(1'b0), 1'b1, 1'b0, T_SIGN);
    repeat (2) driveCycle(makePair(FWD_NONE, validCode()), makeOpIn(1'b1), 1'b1, 1'b0, T_SIGN);
    repeat (2) driveCycle(makePair(FWD_NONE, FWD_NONE), makeOpIn(1'b0), 1'b1, 1'b0, T_SIGN);

    for (i = 0; i < STALL_CYCLES; i++) begin
      driveCycle(makePair(randomCode(), randomCode()), makeOpIn(randomBit()), randomBit(),
                 randomStall(), T_STALL);
    end

    for (i = 0; i < RAND_CYCLES; i++) begin
      driveCycle(makePair(randomCode(), randomCode()), makeOpIn(randomBit()), randomBit(),
                 1'b0, T_RANDOM);
    end

    // let the last items drain out of both stages
    repeat (4) driveCycle(makePair(FWD_NONE, FWD_NONE), '0, 1'b0, 1'b0, T_DRAIN);
    @(negedge clk);
    #10;
    finishRun(1'b0);
  end

endmodule

/* dv/rsForward_props.sv */
// bound checks on the forward path output for reset clearing and stall hold
`timescale 1ns/1ps

module rsForward_props
  import rsDataPkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    stall,
  input opData_t newData
);

  // number of assertion failures so far
  int failCount = 0;

  property resetClears;
    @(posedge clk) rst |=> (newData == '0);
  endproperty

  // a stalled edge must leave the output register alone
  property stallHolds;
    @(posedge clk) (stall && !rst) |=> $stable(newData);
  endproperty

  resetClearsChk: assert property (resetClears)
    else begin
      failCount++;
      $error("newData was not cleared by reset");
    end

  stallHoldsChk: assert property (stallHolds)
    else begin
      failCount++;
      $error("newData changed across a stalled edge");
    end

endmodule

bind rsForwardTop rsForward_props propsInst (
  .clk     (clk),
  .rst     (rst),
  .stall   (stall),
  .newData (newData)
);

/* hw/rsForwardTop.sv */
// reservation station operand forward path with decode and execute stages
`timescale 1ns/1ps

module rsForwardTop
  import rsDataPkg::*;
  import rsCtrlPkg::*;
#(
  parameter int LOW_WIDTH = 16,    // low field that is never filled
  parameter bit FILL_ONES = 1'b0   // fill value for the upper field
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,    // freezes both stages
  input  fwdPair_t codes,
  input  opIn_t    opIn,
  input  logic     sxtEn,
  input  fuBus_t   fuLive,   // results of the current cycle
  input  fuBus_t   fuLate,   // same results delayed by one cycle
  output opData_t  newData
);

  // select passed from decode to execute
  srcSel_t srcSel;

  fwdDecode decodeStage (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .codes  (codes),
    .opIn   (opIn),
    .sxtEn  (sxtEn),
    .srcSel (srcSel)
  );

  operandForward #(
    .LOW_WIDTH (LOW_WIDTH),
    .FILL_ONES (FILL_ONES)
  ) executeStage (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .srcSel  (srcSel),
    .fuLive  (fuLive),
    .fuLate  (fuLate),
    .newData (newData)
  );

endmodule

/* hw/operandForward.sv */
// operand execute stage that picks the forwarded word, sign-fills it and registers it
`timescale 1ns/1ps

module operandForward
  import rsDataPkg::*;
  import rsCtrlPkg::*;
#(
  parameter int LOW_WIDTH = 16,
  parameter bit FILL_ONES = 1'b0
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    stall,
  input  srcSel_t srcSel,
  input  fuBus_t  fuLive,
  input  fuBus_t  fuLate,
  output opData_t newData
);

  // the filled field runs from LOW_WIDTH up to the bit just under the tag
  localparam opData_t LOW_MASK  = (opData_t'(1) << LOW_WIDTH) - opData_t'(1);
  localparam opData_t TAG_MASK  = opData_t'(1) << (DATA_WIDTH - 1);
  localparam opData_t FILL_MASK = ~(LOW_MASK | TAG_MASK);

  opData_t livePick;
  opData_t latePick;
  opData_t picked;
  opData_t filled;

  // decode never hands over an index past the last unit
  assign livePick = fuLive.fu[srcSel.unit];
  assign latePick = fuLate.fu[srcSel.unit];

  always_comb begin
    case (srcSel.kind)
      SRC_LIVE: begin
        picked = livePick;
      end
      SRC_LATE: begin
        picked = latePick;
      end
      SRC_AUX: begin
        picked = srcSel.auxData;
      end
      default: begin
        picked = srcSel.oldData;
      end
    endcase
  end

  always_comb begin
    filled = picked;
    if (srcSel.sxt) begin
      if (FILL_ONES) begin
        filled = picked | FILL_MASK;
      end else begin
        filled = picked & ~FILL_MASK;
      end
    end
  end

  // result register, the buses are sampled one edge after their codes
  always_ff @(posedge clk) begin
    if (rst) begin
      newData <= '0;
    end else if (!stall) begin
      newData <= filled;
    end
  end

endmodule

/* hw/fwdDecode.sv */
// forward decode stage that resolves code priority and registers the source select
`timescale 1ns/1ps

module fwdDecode
  import rsDataPkg::*;
  import rsCtrlPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,
  input  fwdPair_t codes,
  input  opIn_t    opIn,
  input  logic     sxtEn,
  output srcSel_t  srcSel
);

  srcSel_t selNext;
  logic    liveValid;
  logic    lateValid;

  // codes beyond the last unit alias onto it
  function automatic logic [UNIT_W-1:0] unitOf(input fwdCode_t code);
    logic [UNIT_W-1:0] idx;
    if (code >= FWD_LAST_FU) begin
      idx = UNIT_W'(FWD_LAST_FU);
    end else begin
      idx = UNIT_W'(code);
    end
    return idx;
  endfunction

  assign liveValid = (codes.live != FWD_NONE);
  assign lateValid = (codes.late != FWD_NONE);

  always_comb begin
    selNext.kind    = SRC_OLD;
    selNext.unit    = '0;
    selNext.oldData = opIn.oldData;
    selNext.auxData = opIn.auxData;
    selNext.sxt     = sxtEn;

    if (liveValid) begin
      // live wins when both codes are valid
      selNext.kind = SRC_LIVE;
      selNext.unit = unitOf(codes.live);
    end else if (opIn.auxEn) begin
      selNext.kind = SRC_AUX;  // aux only overrides the late path
    end else if (lateValid) begin
      selNext.kind = SRC_LATE;
      selNext.unit = unitOf(codes.late);
    end
  end

  // codes are taken one cycle ahead of the bus data they point at
  always_ff @(posedge clk) begin
    if (rst) begin
      srcSel.kind    <= SRC_OLD;
      srcSel.unit    <= '0;
      srcSel.oldData <= '0;
      srcSel.auxData <= '0;
      srcSel.sxt     <= 1'b0;
    end else if (!stall) begin
      srcSel <= selNext;
    end
  end

endmodule

/* hw/rsCtrlPkg.sv */
// reservation station forward path control types for codes and source selection
package rsCtrlPkg;

  import rsDataPkg::*;

  typedef logic [3:0] fwdCode_t;

  // no forwarding requested on this path
  localparam fwdCode_t FWD_NONE = 4'd15;

  // highest real unit, codes 9 through 14 all land here
  localparam fwdCode_t FWD_LAST_FU = 4'd9;

  // live code names this cycle's bus, late code the copy one cycle older
  typedef struct packed {
    fwdCode_t live;
    fwdCode_t late;
  } fwdPair_t;

  typedef enum logic [1:0] {
    SRC_OLD  = 2'd0,
    SRC_LIVE = 2'd1,
    SRC_LATE = 2'd2,
    SRC_AUX  = 2'd3
  } srcKind_t;

  // everything the execute stage needs one cycle after decode
  typedef struct packed {
    srcKind_t          kind;
    logic [UNIT_W-1:0] unit;     // only meaningful for the live and late kinds
    opData_t           oldData;
    opData_t           auxData;
    logic              sxt;      // fill the upper field of the result
  } srcSel_t;

endpackage

/* hw/rsDataPkg.sv */
// reservation station forward path data types for operands and result buses
package rsDataPkg;

  // a 64-bit value with one tag bit in the top position
  localparam int DATA_WIDTH = 65;

  // functional units that drive a result bus
  localparam int NUM_FU = 10;

  // width of a unit index in the source select
  localparam int UNIT_W = $clog2(NUM_FU);

  typedef logic [DATA_WIDTH-1:0] opData_t;

  // one word per functional unit, indexed by unit number
  // the same layout carries the live results and the copies one cycle older
  typedef struct packed {
    opData_t [NUM_FU-1:0] fu;
  } fuBus_t;

  // per-slot operand inputs presented together with the forward codes
  typedef struct packed {
    opData_t oldData;  // value already held in the station
    opData_t auxData;  // link value for the jump-and-link-register case
    logic    auxEn;    // aux value replaces the late path
  } opIn_t;

endpackage
